// ==== src/soc_defines.svh ====
`ifndef soc_defines_svh
`define soc_defines_svh

// ROM region, writes are dropped
`define rom_base 32'h0000_0000
`define rom_size 32'h0000_1000

// RAM region directly above ROM
`define ram_base 32'h0000_1000
`define ram_size 32'h0000_2000

// Single-word peripheral registers
`define uart_addr 32'h0000_4000
`define kbd_addr 32'h0000_4004
`define irq_addr 32'h0000_4008

// Words behind ROM and RAM together
`define mem_words 3072

// Clocks per serial bit
`define uart_clks_per_bit 16

`endif

// ==== src/bus_pkg.sv ====
package bus_pkg;

    // Byte address and data word on the bus
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Target of one bus access
    typedef enum logic [2:0] {
        region_rom,
        region_ram,
        region_uart,
        region_kbd,
        region_irq,
        region_none
    } region_t;

    // 0 idle, 1 key press, 2 transmit done
    typedef logic [3:0] irq_vector_t;

endpackage

// ==== src/kbd_pkg.sv ====
package kbd_pkg;

    // Raw set-2 scan code from the keyboard
    typedef logic [7:0] scan_code_t;

    // One-cycle event next to the scan code
    typedef enum logic [1:0] {
        kbd_none,
        kbd_press,
        kbd_release
    } kbd_event_t;

endpackage

// ==== src/system_bus.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module system_bus (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  bus_pkg::bus_addr_t            wb_adr,
    input  bus_pkg::bus_data_t            wb_dat_w,
    output bus_pkg::bus_data_t            wb_dat_r,
    output logic                          wb_ack,
    output logic                          mem_en,
    output logic                          mem_we,
    output logic [$clog2(`mem_words)-1:0] mem_index,
    output bus_pkg::bus_data_t            mem_wdata,
    input  bus_pkg::bus_data_t            mem_rdata,
    output logic                          tx_start,
    output kbd_pkg::scan_code_t           tx_byte,
    input  logic                          tx_busy,
    input  kbd_pkg::kbd_event_t           kbd_event,
    input  kbd_pkg::scan_code_t           scan_code
);
    import bus_pkg::*;
    import kbd_pkg::*;

    typedef enum logic {st_idle, st_access} state_t;

    state_t     state;
    region_t    region;
    region_t    region_q;
    logic       req;
    logic       uart_hold;
    logic       kbd_valid;
    logic       kbd_released;
    scan_code_t kbd_code;

    // Address decode, master holds wb_adr for the whole access
    always_comb begin
        if (wb_adr >= `rom_base && wb_adr < `rom_base + `rom_size) begin
            region = region_rom;
        end else if (wb_adr >= `ram_base && wb_adr < `ram_base + `ram_size) begin
            region = region_ram;
        end else if (wb_adr == `uart_addr) begin
            region = region_uart;
        end else if (wb_adr == `kbd_addr) begin
            region = region_kbd;
        end else if (wb_adr == `irq_addr) begin
            region = region_irq;
        end else begin
            region = region_none;
        end
    end

    // Fresh request only, not the strobe still high during ack
    assign req = wb_cyc && wb_stb && !wb_ack && (state == st_idle);

    // Memory sees the access in the decode cycle
    assign mem_en    = req && (region == region_rom || region == region_ram);
    // ROM writes never reach the array
    assign mem_we    = req && wb_we && (region == region_ram);
    assign mem_index = wb_adr[$clog2(`mem_words)+1:2];
    assign mem_wdata = wb_dat_w;

    // UART data write stalls while a frame is on the line
    assign uart_hold = (region_q == region_uart) && wb_we && tx_busy;
    assign tx_start  = (state == st_access) && (region_q == region_uart)
                       && wb_we && !tx_busy;
    // Low byte only
    assign tx_byte   = wb_dat_w[7:0];

    // Decode cycle, then ack cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= st_idle;
            region_q <= region_none;
            wb_ack   <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (state == st_idle) begin
                if (req) begin
                    state    <= st_access;
                    region_q <= region;
                end
            end else if (!uart_hold) begin
                state  <= st_idle;
                wb_ack <= 1'b1;
            end
        end
    end

    // Read mux, registered so data lines up with wb_ack
    always_ff @(posedge CLOCK_50) begin
        if (state == st_access && !uart_hold) begin
            case (region_q)
                region_rom, region_ram: wb_dat_r <= mem_rdata;
                region_kbd:             wb_dat_r <= {22'd0, kbd_released, kbd_valid, kbd_code};
                region_uart:            wb_dat_r <= {31'd0, tx_busy};
                // Interrupt vector lives on its own pins
                default:                wb_dat_r <= '0;
            endcase
        end
    end

    // Keyboard data register
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            kbd_valid    <= 1'b0;
            kbd_released <= 1'b0;
            kbd_code     <= '0;
        end else if (kbd_event != kbd_none) begin
            // New key wins over a read in the same cycle
            kbd_valid    <= 1'b1;
            kbd_released <= (kbd_event == kbd_release);
            kbd_code     <= scan_code;
        end else if (state == st_access && region_q == region_kbd && !wb_we) begin
            // Clear on read
            kbd_valid <= 1'b0;
        end
    end

endmodule

// ==== src/soc_memory.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_memory (
    input  logic                          CLOCK_50,
    input  logic                          mem_en,
    input  logic                          mem_we,
    input  logic [$clog2(`mem_words)-1:0] mem_index,
    input  bus_pkg::bus_data_t            mem_wdata,
    output bus_pkg::bus_data_t            mem_rdata
);
    import bus_pkg::*;

    // ROM words first, then RAM words
    bus_data_t mem_array [0:`mem_words-1];

    // Simulation start state, no image load
    initial begin
        for (int i = 0; i < `mem_words; i++) begin
            mem_array[i] = '0;
        end
    end

    // Single port, read gets old data on a same-cycle write
    always_ff @(posedge CLOCK_50) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_array[mem_index] <= mem_wdata;
            end
            mem_rdata <= mem_array[mem_index];
        end
    end

endmodule

// ==== src/ps2_receiver.sv ====
`timescale 1ns/100ps

module ps2_receiver (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                PS2_CLK,
    input  logic                PS2_DAT,
    output kbd_pkg::kbd_event_t kbd_event,
    output kbd_pkg::scan_code_t scan_code
);
    import kbd_pkg::*;

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;
    logic [3:0]  bit_cnt;
    logic [10:0] frame_q;
    logic        frame_full;
    logic        frame_good;
    scan_code_t  code_q;
    logic        break_seen;

    // Keyboard samples data on its falling clock
    assign clk_fall = clk_prev && !clk_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            // Idle lines are high
            clk_sync   <= 2'b11;
            dat_sync   <= 2'b11;
            clk_prev   <= 1'b1;
            bit_cnt    <= '0;
            frame_q    <= '0;
            frame_full <= 1'b0;
            frame_good <= 1'b0;
            code_q     <= '0;
            break_seen <= 1'b0;
            kbd_event  <= kbd_none;
            scan_code  <= '0;
        end else begin
            clk_sync   <= {clk_sync[0], PS2_CLK};
            dat_sync   <= {dat_sync[0], PS2_DAT};
            clk_prev   <= clk_sync[1];
            frame_full <= 1'b0;
            kbd_event  <= kbd_none;
            // Stage 1, shift in LSB first, start bit ends up in bit 0
            if (clk_fall) begin
                frame_q <= {dat_sync[1], frame_q[10:1]};
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    frame_full <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            // Stage 2, start low, odd parity, stop high
            frame_good <= frame_full && !frame_q[0] && frame_q[10] && (^frame_q[9:1]);
            if (frame_full) begin
                code_q <= frame_q[8:1];
            end
            // Stage 3, F0 prefix only arms the release flag
            if (frame_good) begin
                if (code_q == 8'hF0) begin
                    break_seen <= 1'b1;
                end else begin
                    kbd_event  <= break_seen ? kbd_release : kbd_press;
                    scan_code  <= code_q;
                    break_seen <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module uart_tx (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       tx_done,
    output logic       uart_txd
);
    localparam int cnt_w = $clog2(`uart_clks_per_bit);

    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       shift_q;
    logic             bit_end;

    // Last clock of the current bit
    assign bit_end  = (clk_cnt == cnt_w'(`uart_clks_per_bit - 1));
    // Line idles high between frames
    assign uart_txd = tx_busy ? shift_q[0] : 1'b1;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                // Start only accepted when idle
                if (tx_start) begin
                    tx_busy <= 1'b1;
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (bit_end) begin
                clk_cnt <= '0;
                // Ten bits, stop bit is the last
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // Stop, data, start; shifts toward bit 0
    always_ff @(posedge CLOCK_50) begin
        if (!tx_busy && tx_start) begin
            shift_q <= {1'b1, tx_byte, 1'b0};
        end else if (tx_busy && bit_end) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

endmodule

// ==== src/irq_controller.sv ====
`timescale 1ns/100ps

module irq_controller (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  kbd_pkg::kbd_event_t  kbd_event,
    input  logic                 tx_done,
    input  logic                 irq_ack,
    output bus_pkg::irq_vector_t irq_vector
);
    import kbd_pkg::*;

    // Bit 0 key press, bit 1 transmit done
    logic [1:0] pending;
    logic [1:0] pending_next;

    always_comb begin
        pending_next = pending;
        // Ack drops the source shown on the vector
        if (irq_ack && irq_vector == 4'd1) begin
            pending_next[0] = 1'b0;
        end
        if (irq_ack && irq_vector == 4'd2) begin
            pending_next[1] = 1'b0;
        end
        // New events win over a same-cycle ack
        if (kbd_event == kbd_press) begin
            pending_next[0] = 1'b1;
        end
        if (tx_done) begin
            pending_next[1] = 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending    <= '0;
            irq_vector <= '0;
        end else begin
            pending <= pending_next;
            // Lowest source number has priority
            if (pending_next[0]) begin
                irq_vector <= 4'd1;
            end else if (pending_next[1]) begin
                irq_vector <= 4'd2;
            end else begin
                irq_vector <= 4'd0;
            end
        end
    end

endmodule

// ==== src/soc_top.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_top (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  bus_pkg::bus_addr_t   wb_adr,
    input  bus_pkg::bus_data_t   wb_dat_w,
    output bus_pkg::bus_data_t   wb_dat_r,
    output logic                 wb_ack,
    input  logic                 PS2_CLK,
    input  logic                 PS2_DAT,
    output logic                 uart_txd,
    output bus_pkg::irq_vector_t irq_vector,
    input  logic                 irq_ack
);
    import bus_pkg::*;
    import kbd_pkg::*;

    // Bus to memory
    logic                          mem_en;
    logic                          mem_we;
    logic [$clog2(`mem_words)-1:0] mem_index;
    bus_data_t                     mem_wdata;
    bus_data_t                     mem_rdata;

    // Bus to serial transmitter
    logic       tx_start;
    scan_code_t tx_byte;
    logic       tx_busy;
    logic       tx_done;

    // Keyboard events to bus and interrupts
    kbd_event_t kbd_event;
    scan_code_t scan_code;

    system_bus u_system_bus (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_index (mem_index),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx_busy   (tx_busy),
        .kbd_event (kbd_event),
        .scan_code (scan_code)
    );

    soc_memory u_soc_memory (
        .CLOCK_50  (CLOCK_50),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_index (mem_index),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    ps2_receiver u_ps2_receiver (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .PS2_CLK   (PS2_CLK),
        .PS2_DAT   (PS2_DAT),
        .kbd_event (kbd_event),
        .scan_code (scan_code)
    );

    // Replaces the vendor JTAG UART
    uart_tx u_uart_tx (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done),
        .uart_txd (uart_txd)
    );

    irq_controller u_irq_controller (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .kbd_event  (kbd_event),
        .tx_done    (tx_done),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector)
    );

endmodule

// ==== verif/soc_tb.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_tb;
    import bus_pkg::*;
    import kbd_pkg::*;

    localparam int bit_clks = `uart_clks_per_bit;

    logic        CLOCK_50;
    logic        KEY0;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    bus_addr_t   wb_adr;
    bus_data_t   wb_dat_w;
    bus_data_t   wb_dat_r;
    logic        wb_ack;
    logic        PS2_CLK;
    logic        PS2_DAT;
    logic        uart_txd;
    irq_vector_t irq_vector;
    logic        irq_ack;

    // Bytes decoded off uart_txd in arrival order
    scan_code_t  rx_bytes[$];
    int unsigned lcg_state = 40;

    soc_top UUT (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .PS2_CLK    (PS2_CLK),
        .PS2_DAT    (PS2_DAT),
        .uart_txd   (uart_txd),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    // 100 ns period
    always #50 CLOCK_50 = ~CLOCK_50;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // LCG step giving an idle gap of 0 to 7 cycles
    function automatic int random_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[18:16]);
    endfunction

    task automatic check_data(input string name, input bus_data_t expected,
                              input bus_data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_vector(input string name, input irq_vector_t expected,
                                input irq_vector_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_byte(input string name, input scan_code_t expected,
                              input scan_code_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    // Field count of one script line
    task automatic require_fields(input string cmd, input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("malformed %s line in test data", cmd));
        end
    endtask

    // Ack sampled mid-cycle together with read data
    task automatic wait_ack(output bus_data_t rdata);
        int waited;
        waited = 0;
        @(negedge CLOCK_50);
        while (wb_ack !== 1'b1) begin
            if (waited == 1000) begin
                abort_run("no bus acknowledge");
            end else begin
                waited++;
                @(negedge CLOCK_50);
            end
        end
        rdata = wb_dat_r;
        // Strobe drops in the cycle after the ack
        @(posedge CLOCK_50);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input bus_addr_t adr, input bus_data_t data);
        bus_data_t ignored;
        @(posedge CLOCK_50);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack(ignored);
    endtask

    task automatic wb_read(input bus_addr_t adr, output bus_data_t data);
        @(posedge CLOCK_50);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack(data);
    endtask

    // Keyboard side of one frame with 20-cycle half periods
    task automatic send_key(input scan_code_t code, input logic good_parity);
        logic [10:0] frame;
        // Stop, odd parity, data LSB first, start
        frame = {1'b1, (~^code) ^ ~good_parity, code, 1'b0};
        @(posedge CLOCK_50);
        for (int i = 0; i < 11; i++) begin
            PS2_DAT <= frame[i];
            repeat (10) @(posedge CLOCK_50);
            PS2_CLK <= 1'b0;
            repeat (20) @(posedge CLOCK_50);
            PS2_CLK <= 1'b1;
            repeat (10) @(posedge CLOCK_50);
        end
        PS2_DAT <= 1'b1;
        repeat (20) @(posedge CLOCK_50);
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        @(negedge CLOCK_50);
        while (irq_vector == 4'd0) begin
            if (waited == 2000) begin
                abort_run("no interrupt raised");
            end else begin
                waited++;
                @(negedge CLOCK_50);
            end
        end
    endtask

    task automatic wait_byte();
        int waited;
        waited = 0;
        while (rx_bytes.size() == 0) begin
            if (waited == 2000) begin
                abort_run("no serial byte received");
            end else begin
                waited++;
                @(negedge CLOCK_50);
            end
        end
    endtask

    // One-cycle ack pulse
    task automatic ack_irq();
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
    endtask

    // Serial monitor sampling 8N1 frames mid-bit
    initial begin : uart_monitor
        scan_code_t rx;
        int         idle;
        forever begin
            idle = 0;
            @(negedge CLOCK_50);
            while (uart_txd !== 1'b0) begin
                if (idle == 50000) begin
                    abort_run("serial line idle too long");
                end else begin
                    idle++;
                    @(negedge CLOCK_50);
                end
            end
            repeat (bit_clks / 2) @(negedge CLOCK_50);
            if (uart_txd !== 1'b0) begin
                abort_run("start bit on uart_txd too short");
            end
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge CLOCK_50);
                rx[i] = uart_txd;
            end
            repeat (bit_clks) @(negedge CLOCK_50);
            if (uart_txd !== 1'b1) begin
                abort_run("stop bit missing on uart_txd");
            end
            // Push once tx_done has reached the vector
            repeat (bit_clks / 2 + 1) @(negedge CLOCK_50);
            rx_bytes.push_back(rx);
        end
    end

    // Script interpreter
    initial begin : run_script
        int               fd;
        int               n;
        int               parity;
        string            cmd;
        bus_addr_t        adr;
        bus_data_t        value;
        bus_data_t        rdata;
        scan_code_t       code;
        irq_vector_t      vec;
        logic [8*128-1:0] rest;
        CLOCK_50 = 1'b0;
        KEY0     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        PS2_CLK  = 1'b1;
        PS2_DAT  = 1'b1;
        irq_ack  = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        fd = $fopen("verif/soc_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/soc_testdata.txt");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                repeat (random_gap()) @(posedge CLOCK_50);
                if (cmd[0] == "#") begin
                    n = $fgets(rest, fd);
                end else if (cmd == "W") begin
                    n = $fscanf(fd, "%h %h", adr, value);
                    require_fields(cmd, n, 2);
                    wb_write(adr, value);
                end else if (cmd == "R") begin
                    n = $fscanf(fd, "%h %h", adr, value);
                    require_fields(cmd, n, 2);
                    wb_read(adr, rdata);
                    check_data("wb_dat_r", value, rdata);
                end else if (cmd == "K") begin
                    n = $fscanf(fd, "%h %d", code, parity);
                    require_fields(cmd, n, 2);
                    send_key(code, parity != 0);
                end else if (cmd == "U") begin
                    n = $fscanf(fd, "%h", code);
                    require_fields(cmd, n, 1);
                    wait_byte();
                    check_byte("uart_txd", code, rx_bytes.pop_front());
                end else if (cmd == "I") begin
                    n = $fscanf(fd, "%h", vec);
                    require_fields(cmd, n, 1);
                    if (vec != 4'd0) begin
                        wait_irq();
                    end
                    @(negedge CLOCK_50);
                    check_vector("irq_vector", vec, irq_vector);
                    if (vec != 4'd0) begin
                        ack_irq();
                    end
                end else begin
                    abort_run($sformatf("unknown command %s in test data", cmd));
                end
            end
            $fclose(fd);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== verif/soc_testdata.txt ====
# W addr data | R addr expected | K scan_code good_parity(1/0)
# U expected_serial_byte | I expected_vector (nonzero gets acknowledged)
W 00001000 deadbeef
W 00002ffc 12345678
R 00001000 deadbeef
R 00002ffc 12345678
W 00000010 cafef00d
R 00000010 00000000
W 00005000 0badf00d
R 00005000 00000000
K 1c 1
R 00004004 0000011c
R 00004004 0000001c
I 1
I 0
K f0 1
K 1c 1
I 0
R 00004004 0000031c
K 2a 0
R 00004004 0000021c
W 00004000 000001a5
U a5
I 2
I 0
W 00004000 00000041
W 00004000 00000042
R 00004000 00000001
U 41
U 42
I 2
I 0
K 32 1
W 00004000 00000055
U 55
I 1
I 2
I 0

// ==== build.f ====
+incdir+src
src/bus_pkg.sv
src/kbd_pkg.sv
src/system_bus.sv
src/soc_memory.sv
src/ps2_receiver.sv
src/uart_tx.sv
src/irq_controller.sv
src/soc_top.sv
verif/soc_tb.sv

// ==== Makefile ====
# Verilator build and run of the SoC testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search sim.log for the pass line"
	@echo "  clean  remove build output and sim.log"
	@echo "  help   show this list"

obj_dir/Vsoc_tb: build.f src/*.sv src/*.svh verif/soc_tb.sv
	verilator --binary --timing -Wno-fatal --top-module soc_tb -f build.f

test: obj_dir/Vsoc_tb
	./obj_dir/Vsoc_tb > sim.log 2>&1 || true
	@if grep -q "^TEST OK$$" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
